// ==== sources.f ====
+incdir+hw
hw/dcachePkg.sv
hw/tagStore.sv
hw/dataStore.sv
hw/memPort.sv
hw/dcacheCtrl.sv
hw/dcacheTop.sv
verif/dcacheChk.sv
verif/dcacheTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb \
   -f sources.f --Mdir obj_dir -o dcacheSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dcacheSim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi

exit 0

// ==== verif/dcacheTb.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcacheTb;

   localparam int TXNS = 400;
   localparam int FLUSH_CYCLES = `SETS * 2 * 2 * 4 + `SETS + 8;   // worst case waits
   localparam int LIMIT_CYCLES = 16 + TXNS * 40 + FLUSH_CYCLES;

   logic CLK;
   logic nRST;
   logic dmemRen;
   logic dmemWen;
   dcachePkg::addrT dmemAddr;
   dcachePkg::wordT dmemStore;
   logic halt;
   logic dhit;
   dcachePkg::wordT dmemLoad;
   logic flushed;
   logic memRen;
   logic memWen;
   dcachePkg::addrT memAddr;
   dcachePkg::wordT memStore;
   logic memWait;
   dcachePkg::wordT memLoad;

   integer seed = 3442;
   logic [31:0] mem [logic [31:0]];               // main memory behind the cache
   logic [31:0] refMem [logic [31:0]];            // processor view of memory
   int xferCount;                                 // accepted memory words
   int waitLeft;
   logic wordBusy;

   // reference cache state
   logic [`TAG_W-1:0] mTag [2][`SETS];
   logic mValid [2][`SETS];
   logic mDirty [2][`SETS];
   logic mLru [`SETS];
   int hitModel;

   dcacheTop dut0 (.*);

   always #2 CLK = ~CLK;

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (expected !== actual)
         abortRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
   endtask

   function automatic logic [31:0] fillPattern(input logic [31:0] addr);
      return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
   endfunction

   function automatic logic [31:0] memRead(input logic [31:0] addr);
      return mem.exists(addr) ? mem[addr] : fillPattern(addr);
   endfunction

   function automatic logic [31:0] refRead(input logic [31:0] addr);
      return refMem.exists(addr) ? refMem[addr] : fillPattern(addr);
   endfunction

   // reference lookup and update with first-look hit and bus word count
   task automatic modelAccess(input logic [31:0] addr, input logic isWrite,
                              output logic wasHit, output int words);
      logic [`TAG_W-1:0] t;
      logic [2:0] i;
      logic w;
      t = addr[31:6];
      i = addr[5:3];
      wasHit = 1'b0;
      w = 1'b0;
      words = 0;
      if (mValid[0][i] && mTag[0][i] == t)
         wasHit = 1'b1;
      else if (mValid[1][i] && mTag[1][i] == t)
      begin
         wasHit = 1'b1;
         w = 1'b1;
      end
      if (wasHit)
         hitModel++;
      else
      begin
         w = mLru[i];
         words = mDirty[w][i] ? 4 : 2;            // write-back then fill
         mTag[w][i] = t;
         mValid[w][i] = 1'b1;
         mDirty[w][i] = 1'b0;
      end
      mLru[i] = ~w;
      if (isWrite)
         mDirty[w][i] = 1'b1;
   endtask

   task automatic runRequest(input int n, input logic [31:0] addr, input logic isWrite,
                             input logic [31:0] data);
      logic expHit;
      int expWords;
      int startXfer;
      modelAccess(addr, isWrite, expHit, expWords);
      @(negedge CLK);
      dmemAddr = addr;
      dmemRen = !isWrite;
      dmemWen = isWrite;
      dmemStore = data;
      startXfer = xferCount;
      #1;
      checkValue($sformatf("txn %0d first look", n), expHit, dhit);
      while (!dhit)
      begin
         @(negedge CLK);
         #1;
      end
      checkValue($sformatf("txn %0d memory words", n), expWords, xferCount - startXfer);
      if (isWrite)
         refMem[addr] = data;
      else
         checkValue($sformatf("txn %0d read data", n), refRead(addr), dmemLoad);
   endtask

   // memory with 0 to 3 wait cycles per word
   always @(negedge CLK)
   begin
      if (memRen || memWen)
      begin
         if (!wordBusy)
         begin
            wordBusy = 1'b1;
            waitLeft = $unsigned($random(seed)) % 4;
         end
         if (waitLeft > 0)
         begin
            memWait = 1'b1;
            waitLeft--;
         end
         else
         begin
            memWait = 1'b0;
            wordBusy = 1'b0;
            xferCount++;
            if (memWen)
               mem[memAddr] = memStore;
            else
               memLoad = memRead(memAddr);
         end
      end
      else
         memWait = 1'b0;
   end

   initial
   begin
      #(LIMIT_CYCLES * 4);
      abortRun("watchdog expired before the cache reported flushed");
   end

   initial
   begin
      logic [31:0] addr;
      logic [31:0] lastAddr;
      logic [31:0] data;
      logic isWrite;
      logic lastWasWrite;
      int tagSel;
      CLK = 1'b0;
      nRST = 1'b0;
      dmemRen = 1'b0;
      dmemWen = 1'b0;
      dmemAddr = '0;
      dmemStore = '0;
      halt = 1'b0;
      memWait = 1'b0;
      memLoad = '0;
      xferCount = 0;
      waitLeft = 0;
      wordBusy = 1'b0;
      hitModel = 0;
      lastAddr = '0;
      lastWasWrite = 1'b0;
      for (int i = 0; i < `SETS; i++)
      begin
         mLru[i] = 1'b0;
         for (int w = 0; w < 2; w++)
         begin
            mTag[w][i] = '0;
            mValid[w][i] = 1'b0;
            mDirty[w][i] = 1'b0;
         end
      end
      repeat (16) @(negedge CLK);
      nRST = 1'b1;

      for (int n = 0; n < TXNS; n++)
      begin
         if (lastWasWrite && ($unsigned($random(seed)) % 4 == 0))
         begin
            addr = lastAddr;                      // read back the last store
            isWrite = 1'b0;
         end
         else
         begin
            tagSel = $unsigned($random(seed)) % 5;    // 5 tags over 2 ways
            addr = {`TAG_W'(32'h40 + tagSel), 3'($random(seed)), 1'($random(seed)), 2'b00};
            isWrite = 1'($random(seed));
         end
         data = $random(seed);
         runRequest(n, addr, isWrite, data);
         lastAddr = addr;
         lastWasWrite = isWrite;
      end

      @(negedge CLK);
      dmemRen = 1'b0;
      dmemWen = 1'b0;
      halt = 1'b1;
      #1;
      while (!flushed)
      begin
         @(negedge CLK);
         #1;
      end

      checkValue("halt hit count", hitModel, memRead(`HITCNT_ADDR));
      refMem[`HITCNT_ADDR] = hitModel;
      foreach (refMem[a])
         checkValue($sformatf("flush image %h", a), refMem[a], memRead(a));
      foreach (mem[a])
         checkValue($sformatf("flush image %h", a), refRead(a), mem[a]);
      repeat (8)
      begin
         @(negedge CLK);
         #1;
         checkValue("flushed hold", 1, flushed);
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== verif/dcacheChk.sv ====
`timescale 1ns/1ps

module dcacheChk (
   input  logic CLK,
   input  logic nRST,
   input  logic memRen,
   input  logic memWen,
   input  logic memWait,
   input  dcachePkg::addrT memAddr,
   input  logic flushed
);

   busOneWay: assert property (@(posedge CLK) disable iff (!nRST)
      !(memRen && memWen))
      else $error("memRen and memWen are high in the same cycle");

   flushedHolds: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed)
      else $error("flushed dropped before reset");

   // address frozen during a stalled word
   addrHeld: assert property (@(posedge CLK) disable iff (!nRST)
      (memWait && (memRen || memWen)) |=> $stable(memAddr))
      else $error("memAddr changed while memWait was high");

endmodule

bind dcacheTop dcacheChk chk0 (.*);

// ==== hw/dcacheTop.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcacheTop (
   input  logic CLK,
   input  logic nRST,
   input  logic dmemRen,
   input  logic dmemWen,
   input  dcachePkg::addrT dmemAddr,
   input  dcachePkg::wordT dmemStore,
   input  logic halt,
   output logic dhit,
   output dcachePkg::wordT dmemLoad,
   output logic flushed,
   output logic memRen,
   output logic memWen,
   output dcachePkg::addrT memAddr,
   output dcachePkg::wordT memStore,
   input  logic memWait,
   input  dcachePkg::wordT memLoad
);

   dcachePkg::tagT tag;
   dcachePkg::idxT idx;
   logic blkOff;

   dcachePkg::ctrlStateT state;
   dcachePkg::idxT scanIdx;
   dcachePkg::wordT hitCount;
   logic fillEn, fillDirty, wbClean, setDirty, invalidateAll;
   dcachePkg::wayT fillWay, weWay, hitWay, victimWay;
   logic wordWe, weWord, weSrcMem;
   logic hit, victimDirty, scanDirty0, scanDirty1;
   dcachePkg::tagT victimTag, scanTag0, scanTag1;
   dcachePkg::wordT victimWord0, victimWord1;
   dcachePkg::wordT scanWord0Way0, scanWord1Way0, scanWord0Way1, scanWord1Way1;

   assign tag = dmemAddr[31 -: `TAG_W];
   assign idx = dmemAddr[3 +: `IDX_W];
   assign blkOff = dmemAddr[2];

   dcacheCtrl ctrl0 (.*);

   tagStore tags0 (.*);

   dataStore data0 (.*);

   memPort port0 (.*);

endmodule

// ==== hw/dcacheCtrl.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcacheCtrl (
   input  logic CLK,
   input  logic nRST,
   input  logic dmemRen,
   input  logic dmemWen,
   input  logic halt,
   input  logic memWait,
   input  logic hit,
   input  dcachePkg::wayT hitWay,
   input  dcachePkg::wayT victimWay,
   input  logic victimDirty,
   input  logic scanDirty0,
   input  logic scanDirty1,
   output logic dhit,
   output logic flushed,
   output logic memRen,
   output logic memWen,
   output dcachePkg::ctrlStateT state,
   output dcachePkg::idxT scanIdx,
   output dcachePkg::wordT hitCount,
   output logic fillEn,
   output dcachePkg::wayT fillWay,
   output logic fillDirty,
   output logic wbClean,
   output logic setDirty,
   output logic invalidateAll,
   output logic wordWe,
   output dcachePkg::wayT weWay,
   output logic weWord,
   output logic weSrcMem
);

   dcachePkg::ctrlStateT nextState;
   logic req;
   logic missed;                                  // current request missed once
   logic xferDone;

   assign req = dmemRen || dmemWen;
   assign xferDone = !memWait;
   assign dhit = (state == dcachePkg::Idle) && req && hit;
   assign flushed = (state == dcachePkg::Flushed);
   assign setDirty = dhit && dmemWen;
   assign fillWay = victimWay;
   assign fillDirty = dmemWen;                    // store follows in idle anyway
   assign weWay = (state == dcachePkg::Idle) ? hitWay : victimWay;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= dcachePkg::Idle;
         missed <= 1'b0;
         hitCount <= '0;
         scanIdx <= '0;
      end
      else
      begin
         state <= nextState;
         if (dhit)
         begin
            missed <= 1'b0;
            if (!missed)
               hitCount <= hitCount + 1'b1;       // first-look hits only
         end
         else if (state == dcachePkg::Idle && req && !hit)
            missed <= 1'b1;
         if (state == dcachePkg::FlushNext)
            scanIdx <= scanIdx + 1'b1;
      end
   end

   always_comb
   begin
      nextState = state;
      memRen = 1'b0;
      memWen = 1'b0;
      fillEn = 1'b0;
      wbClean = 1'b0;
      invalidateAll = 1'b0;
      wordWe = 1'b0;
      weWord = 1'b0;
      weSrcMem = 1'b0;
      unique case (state)
         dcachePkg::Idle:
         begin
            wordWe = setDirty;                    // store hit
            if (req && !hit)
               nextState = victimDirty ? dcachePkg::WbWord0 : dcachePkg::FillWord0;
            else if (halt && !req)
               nextState = dcachePkg::HaltCount;
         end
         dcachePkg::WbWord0:
         begin
            memWen = 1'b1;
            if (xferDone)
               nextState = dcachePkg::WbWord1;
         end
         dcachePkg::WbWord1:
         begin
            memWen = 1'b1;
            if (xferDone)
            begin
               wbClean = 1'b1;
               nextState = dcachePkg::FillWord0;
            end
         end
         dcachePkg::FillWord0:
         begin
            memRen = 1'b1;
            weSrcMem = 1'b1;
            wordWe = xferDone;
            if (xferDone)
               nextState = dcachePkg::FillWord1;
         end
         dcachePkg::FillWord1:
         begin
            memRen = 1'b1;
            weSrcMem = 1'b1;
            weWord = 1'b1;
            wordWe = xferDone;
            if (xferDone)
               nextState = dcachePkg::Commit;
         end
         dcachePkg::Commit:
         begin
            fillEn = 1'b1;
            nextState = dcachePkg::Idle;
         end
         dcachePkg::HaltCount:
         begin
            memWen = 1'b1;
            if (xferDone)
               nextState = dcachePkg::FlushWay0Word0;
         end
         dcachePkg::FlushWay0Word0:
         begin
            memWen = scanDirty0;
            if (!scanDirty0)
               nextState = dcachePkg::FlushWay1Word0;
            else if (xferDone)
               nextState = dcachePkg::FlushWay0Word1;
         end
         dcachePkg::FlushWay0Word1:
         begin
            memWen = 1'b1;
            if (xferDone)
               nextState = dcachePkg::FlushWay1Word0;
         end
         dcachePkg::FlushWay1Word0:
         begin
            memWen = scanDirty1;
            if (!scanDirty1)
               nextState = dcachePkg::FlushNext;
            else if (xferDone)
               nextState = dcachePkg::FlushWay1Word1;
         end
         dcachePkg::FlushWay1Word1:
         begin
            memWen = 1'b1;
            if (xferDone)
               nextState = dcachePkg::FlushNext;
         end
         dcachePkg::FlushNext:
         begin
            if (scanIdx == dcachePkg::idxT'(`SETS - 1))
            begin
               invalidateAll = 1'b1;              // last set done
               nextState = dcachePkg::Flushed;
            end
            else
               nextState = dcachePkg::FlushWay0Word0;
         end
         dcachePkg::Flushed:
            nextState = dcachePkg::Flushed;
      endcase
   end

endmodule

// ==== hw/memPort.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module memPort (
   input  dcachePkg::ctrlStateT state,
   input  dcachePkg::tagT tag,
   input  dcachePkg::idxT idx,
   input  dcachePkg::tagT victimTag,
   input  dcachePkg::idxT scanIdx,
   input  dcachePkg::tagT scanTag0,
   input  dcachePkg::tagT scanTag1,
   input  dcachePkg::wordT victimWord0,
   input  dcachePkg::wordT victimWord1,
   input  dcachePkg::wordT scanWord0Way0,
   input  dcachePkg::wordT scanWord1Way0,
   input  dcachePkg::wordT scanWord0Way1,
   input  dcachePkg::wordT scanWord1Way1,
   input  dcachePkg::wordT hitCount,
   output dcachePkg::addrT memAddr,
   output dcachePkg::wordT memStore
);

   always_comb
   begin
      memAddr = '0;
      memStore = '0;
      case (state)
         dcachePkg::WbWord0:
         begin
            memAddr = {victimTag, idx, 1'b0, 2'b00};
            memStore = victimWord0;
         end
         dcachePkg::WbWord1:
         begin
            memAddr = {victimTag, idx, 1'b1, 2'b00};
            memStore = victimWord1;
         end
         dcachePkg::FillWord0:
            memAddr = {tag, idx, 1'b0, 2'b00};
         dcachePkg::FillWord1:
            memAddr = {tag, idx, 1'b1, 2'b00};
         dcachePkg::HaltCount:
         begin
            memAddr = `HITCNT_ADDR;
            memStore = hitCount;
         end
         dcachePkg::FlushWay0Word0:
         begin
            memAddr = {scanTag0, scanIdx, 1'b0, 2'b00};
            memStore = scanWord0Way0;
         end
         dcachePkg::FlushWay0Word1:
         begin
            memAddr = {scanTag0, scanIdx, 1'b1, 2'b00};
            memStore = scanWord1Way0;
         end
         dcachePkg::FlushWay1Word0:
         begin
            memAddr = {scanTag1, scanIdx, 1'b0, 2'b00};
            memStore = scanWord0Way1;
         end
         dcachePkg::FlushWay1Word1:
         begin
            memAddr = {scanTag1, scanIdx, 1'b1, 2'b00};
            memStore = scanWord1Way1;
         end
         default: ;                               // no bus traffic
      endcase
   end

endmodule

// ==== hw/dataStore.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dataStore (
   input  logic CLK,
   input  logic nRST,
   input  dcachePkg::idxT idx,
   input  logic blkOff,
   input  dcachePkg::idxT scanIdx,
   input  logic wordWe,
   input  dcachePkg::wayT weWay,                  // way being accessed
   input  logic weWord,
   input  logic weSrcMem,
   input  dcachePkg::wordT memLoad,
   input  dcachePkg::wordT dmemStore,
   output dcachePkg::wordT dmemLoad,
   output dcachePkg::wordT victimWord0,
   output dcachePkg::wordT victimWord1,
   output dcachePkg::wordT scanWord0Way0,
   output dcachePkg::wordT scanWord1Way0,
   output dcachePkg::wordT scanWord0Way1,
   output dcachePkg::wordT scanWord1Way1
);

   dcachePkg::wordT data [2][`SETS][2];           // way, set, word
   logic wrWord;
   dcachePkg::wordT wrData;

   assign wrWord = weSrcMem ? weWord : blkOff;    // fill word number or store offset
   assign wrData = weSrcMem ? memLoad : dmemStore;

   assign dmemLoad = data[weWay][idx][blkOff];
   assign victimWord0 = data[weWay][idx][0];
   assign victimWord1 = data[weWay][idx][1];
   assign scanWord0Way0 = data[0][scanIdx][0];
   assign scanWord1Way0 = data[0][scanIdx][1];
   assign scanWord0Way1 = data[1][scanIdx][0];
   assign scanWord1Way1 = data[1][scanIdx][1];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         data <= '{default: '0};
      else if (wordWe)
         data[weWay][idx][wrWord] <= wrData;
   end

endmodule

// ==== hw/tagStore.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tagStore (
   input  logic CLK,
   input  logic nRST,
   input  dcachePkg::tagT tag,
   input  dcachePkg::idxT idx,
   input  dcachePkg::idxT scanIdx,
   input  logic fillEn,
   input  dcachePkg::wayT fillWay,
   input  logic fillDirty,
   input  logic wbClean,
   input  logic setDirty,
   input  logic dhit,
   input  logic invalidateAll,
   output logic hit,
   output dcachePkg::wayT hitWay,
   output dcachePkg::wayT victimWay,
   output logic victimDirty,
   output dcachePkg::tagT victimTag,
   output dcachePkg::tagT scanTag0,
   output dcachePkg::tagT scanTag1,
   output logic scanDirty0,
   output logic scanDirty1
);

   dcachePkg::tagT tags [2][`SETS];
   logic [1:0][`SETS-1:0] valid;
   logic [1:0][`SETS-1:0] dirty;
   logic [`SETS-1:0] lru;                         // points at next victim
   logic [1:0] match;

   assign match[0] = valid[0][idx] && (tags[0][idx] == tag);
   assign match[1] = valid[1][idx] && (tags[1][idx] == tag);
   assign hit = |match;
   assign hitWay = match[1];
   assign victimWay = lru[idx];
   assign victimDirty = dirty[victimWay][idx];
   assign victimTag = tags[victimWay][idx];
   assign scanTag0 = tags[0][scanIdx];
   assign scanTag1 = tags[1][scanIdx];
   assign scanDirty0 = dirty[0][scanIdx];
   assign scanDirty1 = dirty[1][scanIdx];

   always_ff @(posedge CLK)
   begin
      if (fillEn)
         tags[fillWay][idx] <= tag;
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid <= '0;
         dirty <= '0;
         lru <= '0;
      end
      else if (invalidateAll)
      begin
         valid <= '0;
         dirty <= '0;
      end
      else
      begin
         if (fillEn)
         begin
            valid[fillWay][idx] <= 1'b1;
            dirty[fillWay][idx] <= fillDirty;
            lru[idx] <= ~fillWay;
         end
         if (wbClean)
            dirty[victimWay][idx] <= 1'b0;
         if (setDirty)
            dirty[hitWay][idx] <= 1'b1;
         if (dhit)
            lru[idx] <= ~hitWay;                  // other way is now older
      end
   end

endmodule

// ==== hw/dcachePkg.sv ====
`include "dcache_defines.svh"

package dcachePkg;

   typedef logic [31:0] addrT;               // tag, idx, blkOff, 2 byte bits
   typedef logic [`TAG_W-1:0] tagT;
   typedef logic [`IDX_W-1:0] idxT;
   typedef logic [`WORD_W-1:0] wordT;
   typedef logic wayT;

   typedef enum logic [3:0]
   {
      Idle, WbWord0, WbWord1, FillWord0, FillWord1, Commit, HaltCount,
      FlushWay0Word0, FlushWay0Word1, FlushWay1Word0, FlushWay1Word1,
      FlushNext, Flushed
   } ctrlStateT;

endpackage

// ==== hw/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address = tag | index | block offset | byte offset
`define TAG_W 26
`define IDX_W 3

`define SETS 8
`define WORD_W 32

// hit count lands here on halt
`define HITCNT_ADDR 32'h0000_3100

`endif
